//--- common/oflow_pkg.sv
// optical-flow frame history store.
// shared widths, memory geometry, history limits and the bus structs
// used between the feature writer, history reader, arbiter and buffer.

package oflow_pkg;

	// ****************************************
	// widths and sizes
	// ****************************************
	localparam int DATA_WIDTH                  = 16;  // one descriptor word.
	localparam int MEM_DEPTH                   = 128; // words in the shared memory.
	localparam int ADDR_WIDTH                  = 7;   // log2 of MEM_DEPTH.
	localparam int TOTAL_FRAME_NUM_WIDTH       = 8;   // frames 0..255.
	localparam int NUM_OF_HISTORY_FRAMES_WIDTH = 3;   // holds counts 1..5.
	localparam int MAX_HISTORY_FRAMES          = 5;   // largest legal count.
	localparam int OFFSET_WIDTH                = 5;   // offset inside a region.
	localparam int MAX_FEATS_PER_FRAME         = 25;  // smallest region, count of 5.

	// ****************************************
	// payload types
	// ****************************************

	// one feature strobe from extraction.
	typedef struct packed {
		logic [OFFSET_WIDTH-1:0] offset; // slot inside the frame region.
		logic [DATA_WIDTH-1:0]   data;   // descriptor word.
	} feat_t;

	// request on the shared buffer bus, always a pair of words.
	typedef struct packed {
		logic                             we;        // 1 write, 0 read.
		logic [TOTAL_FRAME_NUM_WIDTH-1:0] frame_num; // frame that owns the region.
		logic [OFFSET_WIDTH-1:0]          offset_0;  // port 0 offset.
		logic [OFFSET_WIDTH-1:0]          offset_1;  // port 1 offset.
		logic [DATA_WIDTH-1:0]            data_0;    // port 0 write word.
		logic [DATA_WIDTH-1:0]            data_1;    // port 1 write word.
	} mem_req_t;

	// read data coming back from the buffer.
	typedef struct packed {
		logic [DATA_WIDTH-1:0] data_0; // word at offset_0.
		logic [DATA_WIDTH-1:0] data_1; // word at offset_1.
	} mem_rsp_t;

endpackage

//--- hw/oflow_mem_buffer/oflow_mem.sv
// dual-port descriptor memory.
// 128 words, two independent write ports and registered reads.

`timescale 1ns/1ns

module oflow_mem (
	input  logic                             clk,
	input  logic                             reset_N,
	input  logic [oflow_pkg::ADDR_WIDTH-1:0] address_0,
	input  logic [oflow_pkg::ADDR_WIDTH-1:0] address_1,
	input  logic [oflow_pkg::DATA_WIDTH-1:0] data_in_0,
	input  logic [oflow_pkg::DATA_WIDTH-1:0] data_in_1,
	input  logic                             we_0,
	input  logic                             we_1,
	input  logic                             oe_0,
	input  logic                             oe_1,
	output logic [oflow_pkg::DATA_WIDTH-1:0] data_out_0,
	output logic [oflow_pkg::DATA_WIDTH-1:0] data_out_1
);
	import oflow_pkg::*;

	logic [DATA_WIDTH-1:0] mem [MEM_DEPTH]; // register array.

	// ****************************************
	// write ports
	// ****************************************
	always_ff @(posedge clk) begin
		if (!reset_N) begin
			for (int i = 0; i < MEM_DEPTH; i++)
				mem[i] <= '0; // empty store reads as zero.
		end else begin
			if (we_0)
				mem[address_0] <= data_in_0;
			if (we_1)
				mem[address_1] <= data_in_1;
		end
	end

	// ****************************************
	// registered read ports
	// ****************************************
	always_ff @(posedge clk) begin
		if (!reset_N) begin
			data_out_0 <= '0;
			data_out_1 <= '0;
		end else begin
			if (oe_0)
				data_out_0 <= mem[address_0]; // holds when oe low.
			if (oe_1)
				data_out_1 <= mem[address_1];
		end
	end

	a_no_write_clash: assert property (@(posedge clk) disable iff (!reset_N)
		!(we_0 && we_1 && (address_0 == address_1)))
		else $error("both ports write address 0x%h", address_0);

endmodule

//--- hw/oflow_mem_buffer/oflow_mem_buffer.sv
// frame history buffer.
// latches the history count, splits the memory into one region per
// history frame and maps frame-relative offsets onto memory addresses.

`timescale 1ns/1ns

module oflow_mem_buffer (
	input  logic                                             clk,
	input  logic                                             reset_N,
	input  logic [oflow_pkg::TOTAL_FRAME_NUM_WIDTH-1:0]       frame_num,
	input  logic [oflow_pkg::NUM_OF_HISTORY_FRAMES_WIDTH-1:0] num_of_history_frames,
	input  logic                                             bus_valid,
	input  oflow_pkg::mem_req_t                              bus_req,
	output oflow_pkg::mem_rsp_t                              rsp
);
	import oflow_pkg::*;

	logic [NUM_OF_HISTORY_FRAMES_WIDTH-1:0] hist_count;  // latched count.
	logic                                   count_legal; // input count is 1..5.
	logic [ADDR_WIDTH:0]                    region_size; // words per region, up to 128.
	logic [TOTAL_FRAME_NUM_WIDTH-1:0]       slot_full;   // frame mod count.
	logic [NUM_OF_HISTORY_FRAMES_WIDTH-1:0] slot;        // region index.
	logic [ADDR_WIDTH:0]                    base;        // first word of the region.
	logic [ADDR_WIDTH-1:0]                  addr_0;
	logic [ADDR_WIDTH-1:0]                  addr_1;
	logic                                   we;
	logic                                   oe;
	logic [DATA_WIDTH-1:0]                  data_out_0;
	logic [DATA_WIDTH-1:0]                  data_out_1;

	// ****************************************
	// history count and region geometry
	// ****************************************
	assign count_legal = (num_of_history_frames != '0) &&
		(num_of_history_frames <= MAX_HISTORY_FRAMES); // zero or above 5 falls back to 1.

	always_ff @(posedge clk) begin
		if (!reset_N)
			hist_count <= NUM_OF_HISTORY_FRAMES_WIDTH'(1); // single region after reset.
		else if (frame_num == '0) // count only moves at frame 0.
			hist_count <= count_legal ? num_of_history_frames : NUM_OF_HISTORY_FRAMES_WIDTH'(1);
	end

	// whole part of 128 / count.
	always_comb begin
		case (hist_count)
			3'd2:    region_size = (ADDR_WIDTH+1)'(MEM_DEPTH / 2);
			3'd3:    region_size = (ADDR_WIDTH+1)'(MEM_DEPTH / 3); // 42, two words spare.
			3'd4:    region_size = (ADDR_WIDTH+1)'(MEM_DEPTH / 4);
			3'd5:    region_size = (ADDR_WIDTH+1)'(MEM_DEPTH / 5); // 25, three words spare.
			default: region_size = (ADDR_WIDTH+1)'(MEM_DEPTH);
		endcase
	end

	// ****************************************
	// address mapping
	// ****************************************
	assign slot_full = bus_req.frame_num % TOTAL_FRAME_NUM_WIDTH'(hist_count); // rotation.
	assign slot      = slot_full[NUM_OF_HISTORY_FRAMES_WIDTH-1:0]; // always below 5.
	assign base      = region_size * (ADDR_WIDTH+1)'(slot); // max 4 * 25 = 100.

	assign addr_0 = base[ADDR_WIDTH-1:0] + ADDR_WIDTH'(bus_req.offset_0);
	assign addr_1 = base[ADDR_WIDTH-1:0] + ADDR_WIDTH'(bus_req.offset_1);

	assign we = bus_valid & bus_req.we;  // commit at end of bus cycle.
	assign oe = bus_valid & ~bus_req.we; // data one cycle later.

	oflow_mem i_oflow_mem (
		.clk        (clk),
		.reset_N    (reset_N),
		.address_0  (addr_0),
		.address_1  (addr_1),
		.data_in_0  (bus_req.data_0),
		.data_in_1  (bus_req.data_1),
		.we_0       (we),
		.we_1       (we),
		.oe_0       (oe),
		.oe_1       (oe),
		.data_out_0 (data_out_0),
		.data_out_1 (data_out_1)
	);

	assign rsp = '{data_0: data_out_0, data_1: data_out_1};

	// offsets must stay inside the region picked for the current count.
	a_offset_in_region: assert property (@(posedge clk) disable iff (!reset_N)
		bus_valid |-> ((ADDR_WIDTH+1)'(bus_req.offset_0) < region_size) &&
			((ADDR_WIDTH+1)'(bus_req.offset_1) < region_size))
		else $error("offset outside region, size %0d", region_size);

endmodule

//--- hw/oflow_mem_arbiter.sv
// fixed-priority arbiter for the shared buffer bus.
// the feature writer always wins and the history reader takes idle cycles.

`timescale 1ns/1ns

module oflow_mem_arbiter (
	input  logic                wr_req_valid,
	input  oflow_pkg::mem_req_t wr_req,
	input  logic                rd_req_valid,
	input  oflow_pkg::mem_req_t rd_req,
	output logic                rd_grant,
	output logic                bus_valid,
	output oflow_pkg::mem_req_t bus_req
);
	import oflow_pkg::*;

	mem_req_t rd_req_masked; // reader request with write enable cleared.

	// ****************************************
	// selection
	// ****************************************
	always_comb begin
		rd_req_masked    = rd_req;
		rd_req_masked.we = 1'b0; // a reader never writes.
	end

	assign rd_grant  = rd_req_valid & ~wr_req_valid; // reader only on a free cycle.
	assign bus_valid = wr_req_valid | rd_req_valid;
	assign bus_req   = wr_req_valid ? wr_req : rd_req_masked;

endmodule

//--- hw/oflow_feature_writer.sv
// feature writer.
// pairs incoming descriptor strobes into two-word write requests
// tagged with the current frame number.

`timescale 1ns/1ns

module oflow_feature_writer (
	input  logic                                       clk,
	input  logic                                       reset_N,
	input  logic [oflow_pkg::TOTAL_FRAME_NUM_WIDTH-1:0] frame_num,
	input  logic                                       feat_valid,
	input  oflow_pkg::feat_t                           feat,
	output logic                                       wr_req_valid,
	output oflow_pkg::mem_req_t                        wr_req
);
	import oflow_pkg::*;

	logic  half_full;  // first feature of a pair held.
	feat_t first_feat; // held feature for port 0.

	// ****************************************
	// pair control
	// ****************************************
	always_ff @(posedge clk) begin
		if (!reset_N) begin
			half_full    <= 1'b0;
			wr_req_valid <= 1'b0;
		end else begin
			wr_req_valid <= feat_valid & half_full; // strobe for one cycle.
			if (feat_valid)
				half_full <= ~half_full;
		end
	end

	// pair payload.
	always_ff @(posedge clk) begin
		if (feat_valid && !half_full)
			first_feat <= feat;
		if (feat_valid && half_full) begin
			wr_req.we        <= 1'b1;
			wr_req.frame_num <= frame_num; // current frame region.
			wr_req.offset_0  <= first_feat.offset;
			wr_req.data_0    <= first_feat.data;
			wr_req.offset_1  <= feat.offset;
			wr_req.data_1    <= feat.data;
		end
	end

endmodule

//--- hw/oflow_history_reader.sv
// history reader.
// holds one descriptor-pair lookup, requests it for the frame
// age asked for and returns the pair after the buffer read.

`timescale 1ns/1ns

module oflow_history_reader (
	input  logic                                             clk,
	input  logic                                             reset_N,
	input  logic [oflow_pkg::TOTAL_FRAME_NUM_WIDTH-1:0]       frame_num,
	input  logic [oflow_pkg::NUM_OF_HISTORY_FRAMES_WIDTH-1:0] num_of_history_frames,
	input  logic                                             query_valid,
	input  logic [oflow_pkg::NUM_OF_HISTORY_FRAMES_WIDTH-1:0] query_age,
	input  logic [oflow_pkg::OFFSET_WIDTH-1:0]                query_offset_0,
	input  logic [oflow_pkg::OFFSET_WIDTH-1:0]                query_offset_1,
	input  logic                                             rd_grant,
	input  oflow_pkg::mem_rsp_t                              rsp,
	output logic                                             rd_req_valid,
	output oflow_pkg::mem_req_t                              rd_req,
	output logic                                             result_valid,
	output oflow_pkg::mem_rsp_t                              result
);
	import oflow_pkg::*;

	logic accept; // new query taken into the pending register.

	assign accept = query_valid & ~rd_req_valid; // busy reader drops the query.

	// ****************************************
	// pending request and result strobe
	// ****************************************
	always_ff @(posedge clk) begin
		if (!reset_N) begin
			rd_req_valid <= 1'b0;
			result_valid <= 1'b0;
		end else begin
			result_valid <= rd_req_valid & rd_grant; // data lands next cycle.
			if (rd_req_valid)
				rd_req_valid <= ~rd_grant; // keep asking until granted.
			else if (query_valid)
				rd_req_valid <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			rd_req.we        <= 1'b0;
			rd_req.frame_num <= frame_num - TOTAL_FRAME_NUM_WIDTH'(query_age); // wraps mod 256.
			rd_req.offset_0  <= query_offset_0;
			rd_req.offset_1  <= query_offset_1;
			rd_req.data_0    <= '0; // unused on reads.
			rd_req.data_1    <= '0;
		end
	end

	assign result = rsp; // registered read data from the buffer.

	// ****************************************
	// checks
	// ****************************************
	a_query_range: assert property (@(posedge clk) disable iff (!reset_N)
		query_valid |-> (query_age < num_of_history_frames) &&
			(query_offset_0 < MAX_FEATS_PER_FRAME) && (query_offset_1 < MAX_FEATS_PER_FRAME))
		else $error("query out of range, age %0d", query_age);

	// writer spacing means a lost request wins on the very next cycle.
	a_wait_one: assert property (@(posedge clk) disable iff (!reset_N)
		rd_req_valid && !rd_grant |=> rd_req_valid && rd_grant)
		else $error("read request lost arbitration twice");

endmodule

//--- hw/oflow_top.sv
// optical-flow frame history store, top level.
// feature writer and history reader share one buffer through the arbiter.

`timescale 1ns/1ns

module oflow_top (
	input  logic                                             clk,
	input  logic                                             reset_N,
	input  logic [oflow_pkg::TOTAL_FRAME_NUM_WIDTH-1:0]       frame_num,
	input  logic [oflow_pkg::NUM_OF_HISTORY_FRAMES_WIDTH-1:0] num_of_history_frames,
	input  logic                                             feat_valid,
	input  oflow_pkg::feat_t                                 feat,
	input  logic                                             query_valid,
	input  logic [oflow_pkg::NUM_OF_HISTORY_FRAMES_WIDTH-1:0] query_age,
	input  logic [oflow_pkg::OFFSET_WIDTH-1:0]                query_offset_0,
	input  logic [oflow_pkg::OFFSET_WIDTH-1:0]                query_offset_1,
	output logic                                             result_valid,
	output oflow_pkg::mem_rsp_t                              result
);
	import oflow_pkg::*;

	logic     wr_req_valid;
	mem_req_t wr_req;
	logic     rd_req_valid;
	mem_req_t rd_req;
	logic     rd_grant;
	logic     bus_valid;
	mem_req_t bus_req;
	mem_rsp_t rsp;

	oflow_feature_writer i_oflow_feature_writer (
		.clk          (clk),
		.reset_N      (reset_N),
		.frame_num    (frame_num),
		.feat_valid   (feat_valid),
		.feat         (feat),
		.wr_req_valid (wr_req_valid),
		.wr_req       (wr_req)
	);

	oflow_history_reader i_oflow_history_reader (
		.clk                   (clk),
		.reset_N               (reset_N),
		.frame_num             (frame_num),
		.num_of_history_frames (num_of_history_frames),
		.query_valid           (query_valid),
		.query_age             (query_age),
		.query_offset_0        (query_offset_0),
		.query_offset_1        (query_offset_1),
		.rd_grant              (rd_grant),
		.rsp                   (rsp),
		.rd_req_valid          (rd_req_valid),
		.rd_req                (rd_req),
		.result_valid          (result_valid),
		.result                (result)
	);

	oflow_mem_arbiter i_oflow_mem_arbiter (
		.wr_req_valid (wr_req_valid),
		.wr_req       (wr_req),
		.rd_req_valid (rd_req_valid),
		.rd_req       (rd_req),
		.rd_grant     (rd_grant),
		.bus_valid    (bus_valid),
		.bus_req      (bus_req)
	);

	oflow_mem_buffer i_oflow_mem_buffer (
		.clk                   (clk),
		.reset_N               (reset_N),
		.frame_num             (frame_num),
		.num_of_history_frames (num_of_history_frames),
		.bus_valid             (bus_valid),
		.bus_req               (bus_req),
		.rsp                   (rsp)
	);

endmodule

//--- dv/oflow_tb.sv
// testbench for the optical-flow frame history store.
// runs a stimulus table through the top level and checks lookups
// against a word-level model of the shared memory.

`timescale 1ns/1ns

module oflow_tb;
	import oflow_pkg::*;

	typedef enum logic [2:0] {OP_IDLE, OP_FRAME, OP_FEAT, OP_QUERY, OP_FEAT_QUERY} op_e;

	typedef struct packed {
		op_e                                    op;
		logic [TOTAL_FRAME_NUM_WIDTH-1:0]       frame; // used by OP_FRAME.
		logic [NUM_OF_HISTORY_FRAMES_WIDTH-1:0] count; // used by OP_FRAME.
		logic [OFFSET_WIDTH-1:0]                off_0;
		logic [OFFSET_WIDTH-1:0]                off_1;
		logic [NUM_OF_HISTORY_FRAMES_WIDTH-1:0] age;   // lookup age.
	} entry_t;

	logic                                   clk;
	logic                                   reset_N;
	logic [TOTAL_FRAME_NUM_WIDTH-1:0]       frame_num;
	logic [NUM_OF_HISTORY_FRAMES_WIDTH-1:0] num_of_history_frames;
	logic                                   feat_valid;
	feat_t                                  feat;
	logic                                   query_valid;
	logic [NUM_OF_HISTORY_FRAMES_WIDTH-1:0] query_age;
	logic [OFFSET_WIDTH-1:0]                query_offset_0;
	logic [OFFSET_WIDTH-1:0]                query_offset_1;
	logic                                   result_valid;
	mem_rsp_t                               result;

	entry_t                stim [$];            // stimulus table.
	logic [DATA_WIDTH-1:0] ref_mem [MEM_DEPTH]; // model of the memory words.
	int                    ref_count;           // model of the latched count.
	logic [31:0]           lfsr_state;
	bit                    table_ready;
	int                    n_errors;
	int                    n_checks;

	oflow_top i_oflow_top (
		.clk                   (clk),
		.reset_N               (reset_N),
		.frame_num             (frame_num),
		.num_of_history_frames (num_of_history_frames),
		.feat_valid            (feat_valid),
		.feat                  (feat),
		.query_valid           (query_valid),
		.query_age             (query_age),
		.query_offset_0        (query_offset_0),
		.query_offset_1        (query_offset_1),
		.result_valid          (result_valid),
		.result                (result)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk; // 8 ns period.
	end

	// ****************************************
	// helpers
	// ****************************************
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1); // x^32+x^22+x^2+x+1.
	endfunction

	task automatic rand_word(output logic [DATA_WIDTH-1:0] w);
		for (int b = 0; b < DATA_WIDTH; b++) begin
			lfsr_state = lfsr_next(lfsr_state); // one step per bit.
			w[b]       = lfsr_state[0];
		end
	endtask

	// region base is slot times the whole part of 128 / count.
	function automatic int ref_addr(input logic [TOTAL_FRAME_NUM_WIDTH-1:0] frame,
		input int count, input logic [OFFSET_WIDTH-1:0] off);
		int size;
		int slot;
		size = MEM_DEPTH / count;
		slot = int'(frame) % count;
		return slot * size + int'(off);
	endfunction

	task automatic tick();
		@(posedge clk);
		#1; // drive and sample just after the edge.
	endtask

	task automatic add_entry(input op_e op, input int frame, input int count,
		input int off_0, input int off_1, input int age);
		entry_t e;
		e.op    = op;
		e.frame = TOTAL_FRAME_NUM_WIDTH'(frame);
		e.count = NUM_OF_HISTORY_FRAMES_WIDTH'(count);
		e.off_0 = OFFSET_WIDTH'(off_0);
		e.off_1 = OFFSET_WIDTH'(off_1);
		e.age   = NUM_OF_HISTORY_FRAMES_WIDTH'(age);
		stim.push_back(e);
	endtask

	task automatic build_table();
		add_entry(OP_IDLE, 0, 1, 0, 0, 0);   // quiet after reset.
		add_entry(OP_QUERY, 0, 1, 3, 17, 0); // empty store.
		add_entry(OP_FRAME, 0, 1, 0, 0, 0);
		add_entry(OP_FEAT, 0, 1, 0, 1, 0);
		add_entry(OP_FEAT, 0, 1, 24, 12, 0);
		add_entry(OP_QUERY, 0, 1, 0, 24, 0);
		add_entry(OP_QUERY, 0, 1, 1, 12, 0);
		// ****************************************
		// rotation and overwrite for counts 2..5
		// ****************************************
		for (int c = 2; c <= MAX_HISTORY_FRAMES; c++) begin
			for (int f = 0; f < c; f++) begin
				add_entry(OP_FRAME, f, c, 0, 0, 0); // frame 0 relatches the count.
				add_entry(OP_FEAT, f, c, 0, 24, 0);
				add_entry(OP_FEAT, f, c, f + 1, f + 7, 0);
			end
			for (int a = 0; a < c; a++) begin
				add_entry(OP_QUERY, c - 1, c, 0, 24, a);
				add_entry(OP_QUERY, c - 1, c, c - a, c - a + 6, a);
			end
			add_entry(OP_FRAME, c + 1, c, 0, 0, 0); // lands on slot 1 again.
			add_entry(OP_FEAT, c + 1, c, 0, 24, 0);
			add_entry(OP_QUERY, c + 1, c, 0, 24, 0);
			add_entry(OP_FRAME, c + 2, c, 0, 0, 0);
			add_entry(OP_QUERY, c + 2, c, 0, 24, 1);
		end
		// lookups racing a write request.
		add_entry(OP_FRAME, 0, 3, 0, 0, 0);
		add_entry(OP_FEAT_QUERY, 0, 3, 5, 9, 0);
		add_entry(OP_FRAME, 1, 3, 0, 0, 0);
		add_entry(OP_FEAT_QUERY, 1, 3, 10, 11, 1);
		// frame wrap at count 1 then count 4.
		add_entry(OP_FRAME, 0, 1, 0, 0, 0);
		for (int f = 254; f < 258; f++) begin
			add_entry(OP_FRAME, f % 256, 1, 0, 0, 0);
			add_entry(OP_FEAT, f % 256, 1, 2, 20, 0);
			add_entry(OP_QUERY, f % 256, 1, 2, 20, 0);
		end
		add_entry(OP_FRAME, 0, 4, 0, 0, 0);
		for (int f = 254; f < 258; f++) begin
			add_entry(OP_FRAME, f % 256, 4, 0, 0, 0);
			add_entry(OP_FEAT, f % 256, 4, 3, 21, 0);
			if (f == 255 || f == 257) begin
				for (int a = 0; a < 4; a++)
					add_entry(OP_QUERY, f % 256, 4, 3, 21, a); // ages across the wrap.
			end
		end
	endtask

	// ****************************************
	// operations
	// ****************************************
	task automatic set_frame(input entry_t e);
		frame_num             = e.frame;
		num_of_history_frames = e.count;
		if (e.frame == '0)
			ref_count = int'(e.count); // buffer latches only at frame 0.
		tick();
		tick();
	endtask

	task automatic drive_query(input entry_t e);
		query_valid    = 1'b1;
		query_age      = e.age;
		query_offset_0 = e.off_0;
		query_offset_1 = e.off_1;
	endtask

	task automatic wait_result(input entry_t e, input int want_lat);
		logic [TOTAL_FRAME_NUM_WIDTH-1:0] target;
		logic [DATA_WIDTH-1:0]            exp_0;
		logic [DATA_WIDTH-1:0]            exp_1;
		int                               lat;
		target = frame_num - {{(TOTAL_FRAME_NUM_WIDTH-NUM_OF_HISTORY_FRAMES_WIDTH){1'b0}}, e.age};
		exp_0  = ref_mem[ref_addr(target, ref_count, e.off_0)];
		exp_1  = ref_mem[ref_addr(target, ref_count, e.off_1)];
		lat    = 1; // one edge already past the query.
		while (!result_valid && lat < 5) begin
			tick();
			lat++;
		end
		n_checks++;
		if (!result_valid) begin
			$display("result_valid never rose within 5 cycles of the query");
			n_errors++;
		end else begin
			if (lat != want_lat) begin
				$display("result_valid came %0d cycles after the query, expected %0d",
					lat, want_lat);
				n_errors++;
			end
			if (result.data_0 != exp_0) begin
				$display("Mismatch result.data_0: got 0x%h, expected 0x%h", result.data_0, exp_0);
				n_errors++;
			end
			if (result.data_1 != exp_1) begin
				$display("Mismatch result.data_1: got 0x%h, expected 0x%h", result.data_1, exp_1);
				n_errors++;
			end
		end
		tick(); // keeps queries 4 cycles apart.
		tick();
	endtask

	task automatic run_query(input entry_t e);
		drive_query(e);
		tick();
		query_valid = 1'b0;
		wait_result(e, 2); // no write in the way.
	endtask

	// one feature pair with an optional lookup on the second strobe.
	task automatic write_pair(input entry_t e, input bit with_query);
		logic [DATA_WIDTH-1:0] d0;
		logic [DATA_WIDTH-1:0] d1;
		rand_word(d0);
		rand_word(d1);
		feat_valid = 1'b1;
		feat       = '{offset: e.off_0, data: d0};
		tick();
		feat = '{offset: e.off_1, data: d1};
		if (with_query)
			drive_query(e);
		ref_mem[ref_addr(frame_num, ref_count, e.off_0)] = d0; // write lands before the read.
		ref_mem[ref_addr(frame_num, ref_count, e.off_1)] = d1;
		tick();
		feat_valid  = 1'b0;
		query_valid = 1'b0;
		if (with_query)
			wait_result(e, 3); // reader waits out the write.
		else
			tick();
	endtask

	task automatic watch_idle();
		repeat (4) begin
			tick();
			n_checks++;
			if (result_valid) begin
				$display("result_valid went high with no query pending");
				n_errors++;
			end
		end
	endtask

	// ****************************************
	// main sequence and watchdog
	// ****************************************
	initial begin
		int errs_before;
		reset_N               = 1'b0;
		frame_num             = '0;
		num_of_history_frames = NUM_OF_HISTORY_FRAMES_WIDTH'(1);
		feat_valid            = 1'b0;
		feat                  = '0;
		query_valid           = 1'b0;
		query_age             = '0;
		query_offset_0        = '0;
		query_offset_1        = '0;
		lfsr_state            = 32'h923f_356a;
		ref_count             = 1;
		n_errors              = 0;
		n_checks              = 0;
		for (int i = 0; i < MEM_DEPTH; i++)
			ref_mem[i] = '0; // store is cleared by reset.
		build_table();
		table_ready = 1'b1;
		repeat (10) @(posedge clk);
		#1;
		reset_N = 1'b1;
		foreach (stim[i]) begin
			errs_before = n_errors;
			case (stim[i].op)
				OP_IDLE:       watch_idle();
				OP_FRAME:      set_frame(stim[i]);
				OP_FEAT:       write_pair(stim[i], 1'b0);
				OP_QUERY:      run_query(stim[i]);
				default:       write_pair(stim[i], 1'b1);
			endcase
			$display("test %0d %s frame %0d: %s", i, stim[i].op.name(), frame_num,
				(n_errors == errs_before) ? "ok" : "failed");
		end
		$display("%0d tests, %0d checks, %0d failures", stim.size(), n_checks, n_errors);
		if (n_errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

	initial begin
		wait (table_ready);
		repeat (stim.size() * 10 + 12) @(posedge clk); // table length plus reset.
		$display("watchdog expired before the table finished");
		$display("Errors found");
		$finish;
	end

endmodule

//--- files.f
common/oflow_pkg.sv
hw/oflow_mem_buffer/oflow_mem.sv
hw/oflow_mem_buffer/oflow_mem_buffer.sv
hw/oflow_mem_arbiter.sv
hw/oflow_feature_writer.sv
hw/oflow_history_reader.sv
hw/oflow_top.sv
dv/oflow_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the frame history store testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	--top-module oflow_tb \
	-f files.f \
	--Mdir obj_dir \
	-o oflow_sim

./obj_dir/oflow_sim 2>&1 | tee sim.log

if grep -q "^No errors$" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi
